// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module pad_port_tb

run: build
	./obj_dir/Vpad_port_tb > sim.log 2>&1; cat sim.log
	! grep -q "Errors found" sim.log
	grep -q "No errors" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module pad_port_tb

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+include
logic/pad_pkg.sv
logic/pad_port_top.sv
logic/pad_scan_seq.sv
logic/pad_nibble_mux.sv
logic/mouse_nibble_seq.sv
test/pad_port_properties.sv
test/pad_port_tb.sv

// File: include/pad_config.svh
/*
 * Controller port configuration
 * Pad count, button width, mouse axis width and idle timeout width
 */

`ifndef PAD_CONFIG_SVH
`define PAD_CONFIG_SVH

// ========================================
// Pads
// ========================================
`define PAD_COUNT 5
`define PAD_BUTTONS 12

// ========================================
// Mouse
// ========================================
`define MOUSE_AXIS_BITS 8
// Idle counter, phase restarts at saturation
`define MOUSE_TIMEOUT_BITS 15

`endif

// File: logic/mouse_nibble_seq.sv
/*
 * Mouse nibble sequencer
 * Accumulates motion between reports, steps the four nibble phases
 * on clr rises and restarts the sequence after an idle timeout
 */

`default_nettype none

module mouse_nibble_seq #(
	parameter int TIMEOUT_BITS = 15
) (
	input  logic                  CLK_SYS,
	input  logic                  reset,
	input  pad_pkg::mouse_axis_t  mouse_dx,
	input  pad_pkg::mouse_axis_t  mouse_dy,
	input  logic                  mouse_strobe,
	pad_scan_if.mouse             scan,
	output pad_pkg::pad_nibble_t  mouse_high
);

	pad_pkg::mouse_axis_t   acc_x;
	pad_pkg::mouse_axis_t   acc_y;
	pad_pkg::mouse_axis_t   snap_x;
	pad_pkg::mouse_axis_t   snap_y;
	pad_pkg::mouse_phase_e  phase;
	logic [TIMEOUT_BITS-1:0] idle_cnt;
	logic                    idle_full;

	assign idle_full = &idle_cnt;

	// ========================================
	// Idle timeout
	// ========================================
	always_ff @(posedge CLK_SYS) begin
		if (reset || scan.clr)
			idle_cnt <= '0;
		else if (!idle_full)
			idle_cnt <= idle_cnt + TIMEOUT_BITS'(1);
	end

	// ========================================
	// Phase, snapshot and accumulators
	// ========================================
	always_ff @(posedge CLK_SYS) begin
		if (reset) begin
			acc_x  <= '0;
			acc_y  <= '0;
			snap_x <= '0;
			snap_y <= '0;
			phase  <= pad_pkg::phase_y_low;
		end else begin
			if (idle_full)
				phase <= pad_pkg::phase_y_low;

			// A clr rise wins over the timeout
			if (scan.clr_rise) begin
				phase <= pad_pkg::mouse_phase_e'(phase + 2'd1);
				if (phase == pad_pkg::phase_y_low) begin
					snap_x <= acc_x;
					snap_y <= acc_y;
					acc_x  <= '0;
					acc_y  <= '0;
				end
			end

			// New sample replaces the running value, X flipped
			if (mouse_strobe) begin
				acc_x <= -mouse_dx;
				acc_y <= mouse_dy;
			end
		end
	end

	always_comb begin
		mouse_high = snap_y[3:0];
		case (phase)
			pad_pkg::phase_x_high: mouse_high = snap_x[7:4];
			pad_pkg::phase_x_low:  mouse_high = snap_x[3:0];
			pad_pkg::phase_y_high: mouse_high = snap_y[7:4];
			pad_pkg::phase_y_low:  mouse_high = snap_y[3:0];
			default:               mouse_high = snap_y[3:0];
		endcase
	end

endmodule

`default_nettype wire

// File: logic/pad_nibble_mux.sv
/*
 * Nibble mux
 * Builds the active-low 16-bit word of each port, inserts the
 * mouse byte on port 0 and latches the nibble the console asks for
 */

`default_nettype none

module pad_nibble_mux #(
	parameter int PAD_COUNT = 5
) (
	input  logic                   CLK_SYS,
	input  logic                   reset,
	input  pad_pkg::pad_buttons_t  pad0,
	input  pad_pkg::pad_buttons_t  pad1,
	input  pad_pkg::pad_buttons_t  pad2,
	input  pad_pkg::pad_buttons_t  pad3,
	input  pad_pkg::pad_buttons_t  pad4,
	input  logic                   swap,
	input  logic                   mouse_en,
	input  logic                   mouse_left,
	input  logic                   mouse_right,
	input  logic                   sel,
	input  pad_pkg::pad_nibble_t   mouse_high,
	pad_scan_if.mux                scan,
	output pad_pkg::pad_nibble_t   joy_in
);

	// Nibbles from 0 up: run/select/II/I, directions, III-VI, zero
	function automatic logic [15:0] pad_word(input pad_pkg::pad_buttons_t p);
		return ~{4'hF, p[11:8], p[1], p[2], p[0], p[3], p[7:4]};
	endfunction

	pad_pkg::pad_buttons_t pads [0:4];
	logic [15:0]           words [0:PAD_COUNT-1];
	logic [7:0]            mouse_byte;
	logic [15:0]           port_word;

	// Swap only touches the first two pads
	assign pads[0] = swap ? pad1 : pad0;
	assign pads[1] = swap ? pad0 : pad1;
	assign pads[2] = pad2;
	assign pads[3] = pad3;
	assign pads[4] = pad4;

	assign mouse_byte = {mouse_high, ~{pads[0][7:6], mouse_left, mouse_right}};

	always_comb begin
		for (int i = 0; i < PAD_COUNT; i++)
			words[i] = pad_word(pads[i]);
		if (mouse_en)
			words[0] = {mouse_byte, mouse_byte};
	end

	// Unused multitap ports read F, F, F, 0
	always_comb begin
		port_word = 16'h0FFF;
		for (int i = 0; i < PAD_COUNT; i++)
			if (scan.port == 3'(i))
				port_word = words[i];
	end

	always_ff @(posedge CLK_SYS) begin
		if (reset || scan.clr)
			joy_in <= '0;
		else
			joy_in <= port_word[{scan.high_group, sel, 2'b00} +: 4];
	end

endmodule

`default_nettype wire

// File: logic/pad_pkg.sv
/*
 * Controller port types
 * Pad button word, console nibble, multitap port index,
 * mouse motion sample and the mouse nibble phase
 */

`default_nettype none

`include "pad_config.svh"

package pad_pkg;

	// Bit 0 right, 1 left, 2 down, 3 up, 7:4 I/II/select/run, 11:8 III-VI
	typedef logic [`PAD_BUTTONS-1:0] pad_buttons_t;

	// Active low, as the console reads it
	typedef logic [3:0] pad_nibble_t;

	typedef logic [2:0] pad_port_t;

	typedef logic signed [`MOUSE_AXIS_BITS-1:0] mouse_axis_t;

	// Order of the four nibbles sent per mouse report
	typedef enum logic [1:0] {
		phase_x_high = 2'd0,
		phase_x_low  = 2'd1,
		phase_y_high = 2'd2,
		phase_y_low  = 2'd3
	} mouse_phase_e;

endpackage

`default_nettype wire

// File: logic/pad_port_top.sv
/*
 * Controller port of the console core
 * Five pads with swap, multitap stepping, six-button groups and
 * mouse emulation on port 0, read as nibbles through sel and clr
 */

`default_nettype none

`include "pad_config.svh"

// Scan state shared by the sequencer, the nibble mux and the mouse
interface pad_scan_if;
	logic                sel_rise;
	logic                clr_rise;
	logic                clr;
	pad_pkg::pad_port_t  port;
	logic                high_group;

	modport seq   (output sel_rise, output clr_rise, output clr, output port, output high_group);
	modport mux   (input clr, input port, input high_group);
	modport mouse (input clr, input clr_rise);
endinterface

module pad_port_top (
	input  logic                   CLK_SYS,
	input  logic                   reset,
	input  pad_pkg::pad_buttons_t  pad0,
	input  pad_pkg::pad_buttons_t  pad1,
	input  pad_pkg::pad_buttons_t  pad2,
	input  pad_pkg::pad_buttons_t  pad3,
	input  pad_pkg::pad_buttons_t  pad4,
	input  logic                   swap,
	input  logic                   turbotap,
	input  logic                   buttons6,
	input  logic                   mouse_en,
	input  pad_pkg::mouse_axis_t   mouse_dx,
	input  pad_pkg::mouse_axis_t   mouse_dy,
	input  logic                   mouse_left,
	input  logic                   mouse_right,
	input  logic                   mouse_strobe,
	input  logic                   sel,
	input  logic                   clr,
	output pad_pkg::pad_nibble_t   joy_in
);

	pad_pkg::pad_nibble_t mouse_high;

	pad_scan_if scan ();

	pad_scan_seq i_scan_seq (
		.CLK_SYS(CLK_SYS), .reset(reset),
		.sel(sel), .clr(clr),
		.turbotap(turbotap), .buttons6(buttons6),
		.scan(scan.seq)
	);

	mouse_nibble_seq #(.TIMEOUT_BITS(`MOUSE_TIMEOUT_BITS)) i_mouse_seq (
		.CLK_SYS(CLK_SYS), .reset(reset),
		.mouse_dx(mouse_dx), .mouse_dy(mouse_dy),
		.mouse_strobe(mouse_strobe),
		.scan(scan.mouse),
		.mouse_high(mouse_high)
	);

	pad_nibble_mux #(.PAD_COUNT(`PAD_COUNT)) i_nibble_mux (
		.CLK_SYS(CLK_SYS), .reset(reset),
		.pad0(pad0), .pad1(pad1), .pad2(pad2), .pad3(pad3), .pad4(pad4),
		.swap(swap), .mouse_en(mouse_en),
		.mouse_left(mouse_left), .mouse_right(mouse_right),
		.sel(sel), .mouse_high(mouse_high),
		.scan(scan.mux),
		.joy_in(joy_in)
	);

endmodule

`default_nettype wire

// File: logic/pad_scan_seq.sv
/*
 * Scan sequencer
 * Edge detection on the console strobes, multitap port counter
 * and the six-button group flag
 */

`default_nettype none

module pad_scan_seq (
	input  logic CLK_SYS,
	input  logic reset,
	input  logic sel,
	input  logic clr,
	input  logic turbotap,
	input  logic buttons6,
	pad_scan_if.seq scan
);

	logic               sel_q;
	logic               clr_q;
	logic               sel_rise;
	logic               clr_rise;
	pad_pkg::pad_port_t port_q;
	logic               high_group_q;

	// ========================================
	// Strobe edges
	// ========================================
	assign sel_rise = sel & ~sel_q;
	assign clr_rise = clr & ~clr_q;

	always_ff @(posedge CLK_SYS) begin
		if (reset) begin
			sel_q <= 1'b0;
			clr_q <= 1'b0;
		end else begin
			sel_q <= sel;
			clr_q <= clr;
		end
	end

	// ========================================
	// Port counter and button group
	// ========================================
	always_ff @(posedge CLK_SYS) begin
		if (reset) begin
			port_q       <= '0;
			high_group_q <= 1'b0;
		end else if (clr) begin
			port_q <= '0;
			// Alternate groups only in six-button mode
			if (clr_rise)
				high_group_q <= ~high_group_q & buttons6;
		end else if (sel_rise && turbotap) begin
			// Wraps from 7 back to 0
			port_q <= port_q + 3'd1;
		end
	end

	// Outputs to the rest of the port
	assign scan.sel_rise   = sel_rise;
	assign scan.clr_rise   = clr_rise;
	assign scan.clr        = clr;
	assign scan.port       = port_q;
	assign scan.high_group = high_group_q;

endmodule

`default_nettype wire

// File: test/pad_port_properties.sv
/*
 * Scan checks for the controller port
 * Clear behavior, port counter and button group stability
 */

`default_nettype none

module pad_port_properties (
	input logic                 CLK_SYS,
	input logic                 reset,
	input logic                 clr,
	input logic                 clr_rise,
	input logic                 turbotap,
	input logic                 high_group,
	input pad_pkg::pad_port_t   port,
	input pad_pkg::pad_nibble_t joy_in
);

	// Scan clear empties the nibble and rewinds the multitap
	clr_clears_joy: assert property (@(posedge CLK_SYS) disable iff (reset)
		clr |=> joy_in == 4'h0) else $error("joy_in not zero after clr");

	clr_clears_port: assert property (@(posedge CLK_SYS) disable iff (reset)
		clr |=> port == 3'd0) else $error("port not zero after clr");

	group_needs_clr_rise: assert property (@(posedge CLK_SYS) disable iff (reset)
		!clr_rise |=> $stable(high_group)) else $error("high_group moved without clr rise");

	port_held_without_turbotap: assert property (@(posedge CLK_SYS) disable iff (reset)
		(!turbotap && !clr) |=> $stable(port)) else $error("port moved with turbotap low");

endmodule

bind pad_port_top pad_port_properties i_properties (
	.CLK_SYS(CLK_SYS), .reset(reset), .clr(clr), .clr_rise(scan.clr_rise),
	.turbotap(turbotap), .high_group(scan.high_group), .port(scan.port), .joy_in(joy_in)
);

`default_nettype wire

// File: test/pad_port_tb.sv
/*
 * Testbench for the controller port
 * Random stimulus from a fixed seed with every joy_in checked against a model
 */

`default_nettype none

`include "pad_config.svh"

module pad_port_tb;

	localparam int IDLE_WAIT_LIMIT = 40000;

	logic CLK_SYS, reset;
	pad_pkg::pad_buttons_t pad0, pad1, pad2, pad3, pad4;
	logic swap, turbotap, buttons6, mouse_en;
	pad_pkg::mouse_axis_t mouse_dx, mouse_dy;
	logic mouse_left, mouse_right, mouse_strobe, sel, clr;
	pad_pkg::pad_nibble_t joy_in;

	// Model state
	logic sel_q, clr_q, high_group;
	pad_pkg::pad_port_t port;
	pad_pkg::mouse_axis_t acc_x, acc_y, snap_x, snap_y;
	pad_pkg::mouse_phase_e phase;
	logic [`MOUSE_TIMEOUT_BITS-1:0] idle_cnt;
	pad_pkg::pad_nibble_t joy_exp;

	integer seed = 32'hd849;
	int checks = 0, errors = 0, test_start = 0, waited;
	logic [31:0] r;

	pad_port_top i_dut (.*);

	initial begin
		CLK_SYS = 1'b0;
		forever #10 CLK_SYS = ~CLK_SYS;
	end

	// ========================================
	// Reference model
	// ========================================
	function automatic pad_pkg::pad_nibble_t expected_nibble(input logic [1:0] idx);
		pad_pkg::pad_buttons_t b;
		pad_pkg::pad_nibble_t hi;
		case (port)
			3'd0: b = swap ? pad1 : pad0;
			3'd1: b = swap ? pad0 : pad1;
			3'd2: b = pad2;
			3'd3: b = pad3;
			3'd4: b = pad4;
			default: return (idx == 2'd3) ? 4'h0 : 4'hF;
		endcase
		if (port == 3'd0 && mouse_en) begin
			case (phase)
				pad_pkg::phase_x_high: hi = snap_x[7:4];
				pad_pkg::phase_x_low:  hi = snap_x[3:0];
				pad_pkg::phase_y_high: hi = snap_y[7:4];
				default:               hi = snap_y[3:0];
			endcase
			return idx[0] ? hi : ~{b[7], b[6], mouse_left, mouse_right};
		end
		case (idx)
			2'd0: return ~b[7:4];
			2'd1: return ~{b[1], b[2], b[0], b[3]};
			2'd2: return ~b[11:8];
			default: return 4'h0;
		endcase
	endfunction

	task automatic update_model();
		logic sel_rise, clr_rise, idle_full;
		sel_rise = sel & ~sel_q;
		clr_rise = clr & ~clr_q;
		idle_full = &idle_cnt;
		if (reset) begin
			{sel_q, clr_q, high_group, port, idle_cnt, joy_exp} = '0;
			{acc_x, acc_y, snap_x, snap_y} = '0;
			phase = pad_pkg::phase_y_low;
		end else begin
			joy_exp = clr ? 4'h0 : expected_nibble({high_group, sel});
			if (clr_rise) begin
				// Report boundary
				if (phase == pad_pkg::phase_y_low) begin
					snap_x = acc_x;
					snap_y = acc_y;
					acc_x = '0;
					acc_y = '0;
				end
				case (phase)
					pad_pkg::phase_x_high: phase = pad_pkg::phase_x_low;
					pad_pkg::phase_x_low:  phase = pad_pkg::phase_y_high;
					pad_pkg::phase_y_high: phase = pad_pkg::phase_y_low;
					default:               phase = pad_pkg::phase_x_high;
				endcase
			end else if (idle_full) begin
				phase = pad_pkg::phase_y_low;
			end
			if (mouse_strobe) begin
				acc_x = -mouse_dx;
				acc_y = mouse_dy;
			end
			if (clr)
				idle_cnt = '0;
			else if (!idle_full)
				idle_cnt = idle_cnt + 1'b1;
			if (clr)
				port = '0;
			else if (sel_rise && turbotap)
				port = port + 3'd1;
			if (clr_rise)
				high_group = buttons6 ? ~high_group : 1'b0;
			sel_q = sel;
			clr_q = clr;
		end
	endtask

	// ========================================
	// Checks and stimulus helpers
	// ========================================
	task automatic check_nibble(input string name, input pad_pkg::pad_nibble_t expected,
		input pad_pkg::pad_nibble_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Inputs change only on the falling edge
	task automatic run_cycle(input string name);
		@(posedge CLK_SYS);
		update_model();
		@(negedge CLK_SYS);
		check_nibble(name, joy_exp, joy_in);
	endtask

	task automatic pulse_clr(input string name);
		clr = 1'b1;
		run_cycle(name);
		clr = 1'b0;
		run_cycle(name);
	endtask

	task automatic pulse_sel(input string name);
		sel = 1'b1;
		run_cycle(name);
		sel = 1'b0;
		run_cycle(name);
	endtask

	task automatic randomize_pads();
		r = $random(seed);
		pad0 = r[11:0];
		pad1 = r[23:12];
		r = $random(seed);
		pad2 = r[11:0];
		pad3 = r[23:12];
		r = $random(seed);
		pad4 = r[11:0];
		mouse_left = r[12];
		mouse_right = r[13];
	endtask

	task automatic end_test(input string name);
		$display("%s done, %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		reset = 1'b1;
		{swap, turbotap, buttons6, mouse_en, mouse_strobe, sel, clr} = '0;
		{mouse_left, mouse_right, mouse_dx, mouse_dy} = '0;
		{pad0, pad1, pad2, pad3, pad4} = '0;
		repeat (5) run_cycle("reset");
		reset = 1'b0;

		pulse_clr("button_map");
		repeat (40) begin
			randomize_pads();
			sel = r[20];
			run_cycle("button_map");
		end
		end_test("button_map");

		swap = 1'b1;
		turbotap = 1'b1;
		repeat (8) begin
			randomize_pads();
			pulse_clr("swap");
			pulse_sel("swap");
			pulse_sel("swap");
		end
		end_test("swap");

		swap = 1'b0;
		// Alternate groups reach the zero nibble of ports 5 to 7
		buttons6 = 1'b1;
		// Up to 16 pulses wrap the port
		repeat (12) begin
			randomize_pads();
			pulse_clr("multitap");
			repeat (int'(r[19:16]) + 1)
				pulse_sel("multitap");
		end
		turbotap = 1'b0;
		pulse_clr("multitap");
		repeat (6) pulse_sel("multitap");
		end_test("multitap");

		for (int i = 0; i < 12; i++) begin
			buttons6 = (i < 8);
			randomize_pads();
			pulse_clr("six_button");
			pulse_sel("six_button");
		end
		buttons6 = 1'b0;
		end_test("six_button");

		mouse_en = 1'b1;
		repeat (6) begin
			randomize_pads();
			swap = r[14];
			mouse_dx = r[31:24];
			mouse_dy = r[23:16];
			mouse_strobe = 1'b1;
			run_cycle("mouse");
			mouse_strobe = 1'b0;
			repeat (4) begin
				pulse_clr("mouse");
				pulse_sel("mouse");
			end
		end
		// Idle with clr low until the phase restarts
		sel = 1'b1;
		waited = 0;
		while (idle_cnt != '1 && waited < IDLE_WAIT_LIMIT) begin
			run_cycle("mouse_timeout");
			waited++;
		end
		if (idle_cnt != '1) begin
			errors++;
			$display("Timeout: mouse idle counter never saturated");
		end
		repeat (4) run_cycle("mouse_timeout");
		sel = 1'b0;
		repeat (4) begin
			pulse_clr("mouse_timeout");
			pulse_sel("mouse_timeout");
		end
		end_test("mouse");

		repeat (80) begin
			randomize_pads();
			r = $random(seed);
			mouse_dx = r[7:0];
			mouse_dy = r[15:8];
			{swap, turbotap, buttons6, mouse_en, mouse_strobe, sel} = r[21:16];
			clr = (r[23:22] == 2'b00);
			run_cycle("scan_clear");
			if (clr)
				check_nibble("scan_clear", 4'h0, joy_in);
		end
		end_test("scan_clear");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
